//--- rvseed_pkg.sv
package rvseed_pkg;

    localparam int xlen = 64;

    // encodings of add, sub and sltu follow the older core's decoder.
    typedef enum logic [3:0] {
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_add  = 4'b0011,
        alu_sub  = 4'b0100,
        alu_xor  = 4'b0101,
        alu_srl  = 4'b0110,
        alu_sra  = 4'b0111,
        alu_or   = 4'b1000,
        alu_sltu = 4'b1001,
        alu_and  = 4'b1010,
        alu_remu = 4'b1011
    } alu_op_e;

    // the first six values keep the old read flag numbering.
    typedef enum logic [3:0] {
        kind_alu_w   = 4'd0,
        kind_load_w  = 4'd1,
        kind_load_d  = 4'd2,
        kind_alu     = 4'd3,
        kind_load_bu = 4'd4,
        kind_pass_b  = 4'd5,
        kind_store_w = 4'd6,
        kind_store_d = 4'd7,
        kind_store_b = 4'd8
    } exec_kind_e;

    typedef enum logic [1:0] {
        size_b = 2'd0, // value is log2 of the byte count.
        size_w = 2'd2,
        size_d = 2'd3
    } mem_size_e;

    typedef enum logic [1:0] {
        lsu_idle   = 2'd0,
        lsu_setup  = 2'd1,
        lsu_access = 2'd2
    } lsu_state_e;

endpackage

//--- apb_if.sv
`timescale 1ns/1ps

interface apb_if;

    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [rvseed_pkg::xlen-1:0]     paddr;
    logic [rvseed_pkg::xlen-1:0]     pwdata;
    logic [rvseed_pkg::xlen/8-1:0]   pstrb;
    logic [rvseed_pkg::xlen-1:0]     prdata;
    logic                            pready;

    modport master (
        output psel, penable, pwrite, paddr, pwdata, pstrb,
        input  prdata, pready
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata, pstrb,
        output prdata, pready
    );

endinterface

//--- rvseed_alu.sv
`timescale 1ns/1ps

module rvseed_alu (
    input  rvseed_pkg::alu_op_e          op,
    input  logic                         word,
    input  logic                         pass_b,
    input  logic [rvseed_pkg::xlen-1:0]  a,
    input  logic [rvseed_pkg::xlen-1:0]  b,
    output logic [rvseed_pkg::xlen-1:0]  result,
    output logic                         zero
);

    logic [5:0]                  shamt;
    logic [rvseed_pkg::xlen-1:0] raw;
    logic [rvseed_pkg::xlen-1:0] sized;

    assign shamt = b[5:0]; // only the low six bits select the shift.

    always_comb begin
        raw = '0;
        case (op)
            rvseed_pkg::alu_add: begin
                raw = a + b;
            end
            rvseed_pkg::alu_sub: begin
                raw = a - b;
            end
            rvseed_pkg::alu_sll: begin
                raw = a << shamt;
            end
            rvseed_pkg::alu_slt: begin
                raw = {63'b0, $signed(a) < $signed(b)};
            end
            rvseed_pkg::alu_sltu: begin
                raw = {63'b0, a < b};
            end
            rvseed_pkg::alu_xor: begin
                raw = a ^ b;
            end
            rvseed_pkg::alu_srl: begin
                raw = a >> shamt;
            end
            rvseed_pkg::alu_sra: begin
                raw = $signed(a) >>> shamt;
            end
            rvseed_pkg::alu_or: begin
                raw = a | b;
            end
            rvseed_pkg::alu_and: begin
                raw = a & b;
            end
            rvseed_pkg::alu_remu: begin
                // a zero divisor leaves the dividend, as the ISA asks.
                if (b == '0) begin
                    raw = a;
                end else begin
                    raw = a % b;
                end
            end
            default: begin
                raw = '0;
            end
        endcase
    end

    always_comb begin
        if (word) begin
            sized = {{32{raw[31]}}, raw[31:0]};
        end else begin
            sized = raw;
        end
    end

    // lui style pass overrides everything else.
    assign result = pass_b ? b : sized;
    assign zero   = (result == '0);

endmodule

//--- rvseed_lsu.sv
`timescale 1ns/1ps

module rvseed_lsu (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req,
    input  logic                         write,
    input  rvseed_pkg::mem_size_e        size,
    input  logic [rvseed_pkg::xlen-1:0]  addr,
    input  logic [rvseed_pkg::xlen-1:0]  wdata,
    output logic                         done,
    output logic [rvseed_pkg::xlen-1:0]  rdata,
    apb_if.master                        apb
);

    rvseed_pkg::lsu_state_e      state;
    rvseed_pkg::mem_size_e       size_q;
    logic                        write_q;
    logic [rvseed_pkg::xlen-1:0] addr_q;
    logic [rvseed_pkg::xlen-1:0] wdata_q;
    logic [5:0]                  lane_shift;
    logic [rvseed_pkg::xlen-1:0] lane_data;
    logic                        finish;

    assign lane_shift = {addr_q[2:0], 3'b000}; // byte offset in bits.
    assign finish     = (state == rvseed_pkg::lsu_access) && apb.pready;

    assign apb.psel    = (state != rvseed_pkg::lsu_idle);
    assign apb.penable = (state == rvseed_pkg::lsu_access);
    assign apb.pwrite  = write_q;
    assign apb.paddr   = {addr_q[rvseed_pkg::xlen-1:3], 3'b000};
    assign apb.pwdata  = wdata_q << lane_shift;
    assign lane_data   = apb.prdata >> lane_shift;

    always_comb begin
        case (size_q)
            rvseed_pkg::size_b: apb.pstrb = 8'h01 << addr_q[2:0];
            rvseed_pkg::size_w: apb.pstrb = 8'h0f << addr_q[2:0];
            default:            apb.pstrb = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rvseed_pkg::lsu_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                rvseed_pkg::lsu_idle: begin
                    if (req) begin
                        state <= rvseed_pkg::lsu_setup;
                    end
                end
                rvseed_pkg::lsu_setup: begin
                    state <= rvseed_pkg::lsu_access;
                end
                rvseed_pkg::lsu_access: begin
                    if (apb.pready) begin
                        state <= rvseed_pkg::lsu_idle;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= rvseed_pkg::lsu_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req && state == rvseed_pkg::lsu_idle) begin
            addr_q  <= addr;
            size_q  <= size;
            write_q <= write;
            wdata_q <= wdata;
        end
        if (finish) begin
            case (size_q)
                rvseed_pkg::size_b: rdata <= {{(rvseed_pkg::xlen-8){1'b0}}, lane_data[7:0]};
                rvseed_pkg::size_w: rdata <= {{32{lane_data[31]}}, lane_data[31:0]};
                default:            rdata <= apb.prdata;
            endcase
        end
    end

    req_aligned: assert property (@(posedge clk) disable iff (rst)
        req |-> (size == rvseed_pkg::size_b)
             || (size == rvseed_pkg::size_w && addr[1:0] == 2'b00)
             || (addr[2:0] == 3'b000));

    // the top must hold its next request until this unit has answered.
    req_when_idle: assert property (@(posedge clk) disable iff (rst)
        req |-> state == rvseed_pkg::lsu_idle);

endmodule

//--- rvseed_dmem.sv
`timescale 1ns/1ps

module rvseed_dmem #(
    parameter int DEPTH       = 64,
    parameter int WAIT_STATES = 1
) (
    input  logic clk,
    input  logic rst,
    apb_if.slave apb
);

    localparam int idx_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [rvseed_pkg::xlen-1:0] mem [DEPTH];
    logic [idx_w-1:0]            idx;
    logic [cnt_w-1:0]            wait_cnt;
    logic                        ready;

    assign idx = idx_w'((apb.paddr >> 3) % DEPTH); // addresses wrap around the array.

    assign ready      = apb.psel && apb.penable && (wait_cnt == cnt_w'(WAIT_STATES));
    assign apb.pready = ready;
    assign apb.prdata = mem[idx];

    // counts access cycles already spent waiting.
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (apb.psel && apb.penable && !ready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (ready && apb.pwrite) begin
            for (int b = 0; b < rvseed_pkg::xlen / 8; b++) begin
                if (apb.pstrb[b]) begin
                    mem[idx][b*8 +: 8] <= apb.pwdata[b*8 +: 8];
                end
            end
        end
    end

    penable_in_sel: assert property (@(posedge clk) disable iff (rst)
        apb.penable |-> apb.psel);

endmodule

//--- rvseed_exec.sv
`timescale 1ns/1ps

module rvseed_exec #(
    parameter int MEM_DEPTH   = 64,
    parameter int WAIT_STATES = 1
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cmd_valid,
    output logic                         cmd_ready,
    input  rvseed_pkg::alu_op_e          cmd_op,
    input  rvseed_pkg::exec_kind_e       cmd_kind,
    input  logic [rvseed_pkg::xlen-1:0]  src1,
    input  logic [rvseed_pkg::xlen-1:0]  src2,
    input  logic [rvseed_pkg::xlen-1:0]  store_data,
    output logic                         res_valid,
    output logic [rvseed_pkg::xlen-1:0]  res,
    output logic                         res_zero
);

    rvseed_pkg::alu_op_e         op_q;
    rvseed_pkg::exec_kind_e      kind_q;
    logic [rvseed_pkg::xlen-1:0] a_q;
    logic [rvseed_pkg::xlen-1:0] b_q;
    logic [rvseed_pkg::xlen-1:0] wdata_q;
    logic                        busy;
    logic                        alu_pend;
    logic                        lsu_req;
    logic                        accept;
    logic                        cmd_is_mem;
    logic                        is_load;
    logic                        is_store;
    rvseed_pkg::mem_size_e       size;
    rvseed_pkg::alu_op_e         alu_op;
    logic [rvseed_pkg::xlen-1:0] alu_res;
    logic                        alu_zero;
    logic                        lsu_done;
    logic [rvseed_pkg::xlen-1:0] lsu_rdata;

    apb_if apb_bus ();

    assign cmd_ready  = !busy; // one command in flight at most.
    assign accept     = cmd_valid && cmd_ready;
    assign cmd_is_mem = cmd_kind inside {rvseed_pkg::kind_load_w, rvseed_pkg::kind_load_d,
                                         rvseed_pkg::kind_load_bu, rvseed_pkg::kind_store_w,
                                         rvseed_pkg::kind_store_d, rvseed_pkg::kind_store_b};

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        size     = rvseed_pkg::size_d;
        case (kind_q)
            rvseed_pkg::kind_load_w:  begin is_load  = 1'b1; size = rvseed_pkg::size_w; end
            rvseed_pkg::kind_load_d:  begin is_load  = 1'b1; size = rvseed_pkg::size_d; end
            rvseed_pkg::kind_load_bu: begin is_load  = 1'b1; size = rvseed_pkg::size_b; end
            rvseed_pkg::kind_store_w: begin is_store = 1'b1; size = rvseed_pkg::size_w; end
            rvseed_pkg::kind_store_d: begin is_store = 1'b1; size = rvseed_pkg::size_d; end
            rvseed_pkg::kind_store_b: begin is_store = 1'b1; size = rvseed_pkg::size_b; end
            default: ;
        endcase
    end

    // memory kinds borrow the adder for the effective address.
    assign alu_op = (is_load || is_store) ? rvseed_pkg::alu_add : op_q;

    rvseed_alu u_alu (
        .op     (alu_op),
        .word   (kind_q == rvseed_pkg::kind_alu_w),
        .pass_b (kind_q == rvseed_pkg::kind_pass_b),
        .a      (a_q),
        .b      (b_q),
        .result (alu_res),
        .zero   (alu_zero)
    );

    rvseed_lsu u_lsu (
        .clk   (clk),
        .rst   (rst),
        .req   (lsu_req),
        .write (is_store),
        .size  (size),
        .addr  (alu_res),
        .wdata (wdata_q),
        .done  (lsu_done),
        .rdata (lsu_rdata),
        .apb   (apb_bus.master)
    );

    rvseed_dmem #(
        .DEPTH       (MEM_DEPTH),
        .WAIT_STATES (WAIT_STATES)
    ) u_dmem (
        .clk (clk),
        .rst (rst),
        .apb (apb_bus.slave)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            alu_pend  <= 1'b0;
            lsu_req   <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            lsu_req   <= 1'b0;
            if (accept) begin
                busy     <= 1'b1;
                alu_pend <= !cmd_is_mem;
                lsu_req  <= cmd_is_mem;
            end else if (alu_pend || lsu_done) begin
                alu_pend  <= 1'b0;
                busy      <= 1'b0;
                res_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= cmd_op;
            kind_q  <= cmd_kind;
            a_q     <= src1;
            b_q     <= src2;
            wdata_q <= store_data;
        end
        if (alu_pend) begin
            res      <= alu_res;
            res_zero <= alu_zero;
        end else if (lsu_done) begin
            res      <= is_load ? lsu_rdata : alu_res; // a store reports its address.
            res_zero <= is_load ? (lsu_rdata == '0) : alu_zero;
        end
    end

endmodule

//--- tb_rvseed_exec.sv
`timescale 1ns/1ps

module tb_rvseed_exec;

    localparam int timeout_cycles  = 40;
    localparam int mem_min_latency = 4; // three cycles plus one wait state.

    logic                         clk;
    logic                         rst;
    logic                         cmd_valid;
    logic                         cmd_ready;
    rvseed_pkg::alu_op_e          cmd_op;
    rvseed_pkg::exec_kind_e       cmd_kind;
    logic [rvseed_pkg::xlen-1:0]  src1;
    logic [rvseed_pkg::xlen-1:0]  src2;
    logic [rvseed_pkg::xlen-1:0]  store_data;
    logic                         res_valid;
    logic [rvseed_pkg::xlen-1:0]  res;
    logic                         res_zero;

    int         seed = 32'h33fc0c59;
    int         value_errors;
    int         timeout_errors;
    int         accepted;
    int         results;
    logic       hung;
    logic [7:0] shadow [512]; // byte image of the 64 word memory.

    rvseed_exec dut (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_kind   (cmd_kind),
        .src1       (src1),
        .src2       (src2),
        .store_data (store_data),
        .res_valid  (res_valid),
        .res        (res),
        .res_zero   (res_zero)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst && res_valid) begin
            results++;
        end
    end

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic rvseed_pkg::alu_op_e op_at(int n);
        case (n)
            0:       return rvseed_pkg::alu_add;
            1:       return rvseed_pkg::alu_sub;
            2:       return rvseed_pkg::alu_sll;
            3:       return rvseed_pkg::alu_slt;
            4:       return rvseed_pkg::alu_sltu;
            5:       return rvseed_pkg::alu_xor;
            6:       return rvseed_pkg::alu_srl;
            7:       return rvseed_pkg::alu_sra;
            8:       return rvseed_pkg::alu_or;
            9:       return rvseed_pkg::alu_and;
            default: return rvseed_pkg::alu_remu;
        endcase
    endfunction

    function automatic logic [63:0] model_alu(rvseed_pkg::alu_op_e op, logic [63:0] a,
                                              logic [63:0] b);
        logic [5:0]  sh;
        logic [63:0] r;
        sh = b[5:0];
        case (op)
            rvseed_pkg::alu_add:  r = a + b;
            rvseed_pkg::alu_sub:  r = a + ~b + 64'd1;
            rvseed_pkg::alu_sll:  r = a << sh;
            rvseed_pkg::alu_slt:  r = (a[63] != b[63]) ? {63'd0, a[63]} : {63'd0, a < b};
            rvseed_pkg::alu_sltu: r = {63'd0, a < b};
            rvseed_pkg::alu_xor:  r = a ^ b;
            rvseed_pkg::alu_srl:  r = a >> sh;
            rvseed_pkg::alu_sra:  r = (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'd0);
            rvseed_pkg::alu_or:   r = a | b;
            rvseed_pkg::alu_and:  r = a & b;
            default:              r = (b == 64'd0) ? a : a % b;
        endcase
        return r;
    endfunction

    function automatic logic [63:0] shadow_read(rvseed_pkg::exec_kind_e kind, logic [63:0] addr);
        logic [63:0] r;
        int          base;
        base = int'(addr[8:0]);
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = shadow[(base + i) % 512];
        end
        if (kind == rvseed_pkg::kind_load_w) begin
            r = {{32{r[31]}}, r[31:0]};
        end else if (kind == rvseed_pkg::kind_load_bu) begin
            r = {56'd0, r[7:0]};
        end
        return r;
    endfunction

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!cmd_ready && !hung) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timeout: cmd_ready did not return high");
                timeout_errors++;
                hung = 1'b1;
            end
        end
    endtask

    // cycles counts rising edges from acceptance to the result.
    task automatic wait_result(output int cycles);
        cycles = 0;
        while (!res_valid && !hung) begin
            if (cmd_ready) begin
                $display("cmd_ready went high while a command was still in flight");
                value_errors++;
            end
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timeout: no result came back for an accepted command");
                timeout_errors++;
                hung = 1'b1;
            end
        end
    endtask

    task automatic drive_cmd(rvseed_pkg::alu_op_e op, rvseed_pkg::exec_kind_e kind,
                             logic [63:0] a, logic [63:0] b, logic [63:0] d);
        cmd_valid  = 1'b1;
        cmd_op     = op;
        cmd_kind   = kind;
        src1       = a;
        src2       = b;
        store_data = d;
    endtask

    // leaves cmd_valid high at the falling edge after acceptance.
    task automatic send_cmd(rvseed_pkg::alu_op_e op, rvseed_pkg::exec_kind_e kind,
                            logic [63:0] a, logic [63:0] b, logic [63:0] d);
        wait_ready();
        drive_cmd(op, kind, a, b, d);
        @(posedge clk);
        if (!hung) begin
            accepted++;
        end
        @(negedge clk);
    endtask

    task automatic check_result(string name, logic [63:0] expected, int lat, int min_lat,
                                int max_lat);
        if (!hung && res !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, res);
            value_errors++;
        end
        if (!hung && res_zero !== (expected == 64'd0)) begin
            $display("FAILED %s zero: expected %b, actual %b", name, expected == 64'd0, res_zero);
            value_errors++;
        end
        if (!hung && (lat < min_lat || lat > max_lat)) begin
            $display("FAILED %s latency: expected %0d, actual %0d", name, min_lat, lat);
            value_errors++;
        end
    endtask

    task automatic run_cmd(string name, rvseed_pkg::alu_op_e op, rvseed_pkg::exec_kind_e kind,
                           logic [63:0] a, logic [63:0] b, logic [63:0] d,
                           logic [63:0] expected, int min_lat, int max_lat);
        int lat;
        send_cmd(op, kind, a, b, d);
        cmd_valid = 1'b0;
        wait_result(lat);
        check_result(name, expected, lat, min_lat, max_lat);
    endtask

    task automatic alu_cmd(string name, rvseed_pkg::exec_kind_e kind);
        rvseed_pkg::alu_op_e op;
        logic [63:0]         a;
        logic [63:0]         b;
        logic [63:0]         expected;
        int                  pick;
        op   = op_at({$random(seed)} % 11);
        a    = rand64();
        b    = rand64();
        pick = {$random(seed)} % 8;
        if (pick == 0) begin
            b = 64'd0; // zero divisor for remu, zero operand elsewhere.
        end else if (pick == 1) begin
            b = a;
        end
        expected = model_alu(op, a, b);
        if (kind == rvseed_pkg::kind_alu_w) begin
            expected = {{32{expected[31]}}, expected[31:0]};
        end else if (kind == rvseed_pkg::kind_pass_b) begin
            expected = b;
        end
        run_cmd(name, op, kind, a, b, 64'd0, expected, 1, 1);
    endtask

    task automatic mem_cmd(string name, rvseed_pkg::exec_kind_e kind);
        int          nbytes;
        logic [63:0] addr;
        logic [63:0] a;
        logic [63:0] data;
        logic [63:0] expected;
        case (kind)
            rvseed_pkg::kind_load_w, rvseed_pkg::kind_store_w:  nbytes = 4;
            rvseed_pkg::kind_load_bu, rvseed_pkg::kind_store_b: nbytes = 1;
            default:                                            nbytes = 8;
        endcase
        addr = rand64() & ~(64'(nbytes) - 64'd1);
        a    = rand64();
        data = rand64();
        if (kind inside {rvseed_pkg::kind_store_w, rvseed_pkg::kind_store_d,
                         rvseed_pkg::kind_store_b}) begin
            for (int i = 0; i < nbytes; i++) begin
                shadow[int'(addr[8:0]) + i] = data[8*i +: 8];
            end
            expected = addr; // a store reports its effective address.
        end else begin
            expected = shadow_read(kind, addr);
        end
        run_cmd(name, rvseed_pkg::alu_add, kind, a, addr - a, data, expected,
                mem_min_latency, timeout_cycles);
    endtask

    // a second command is held valid while a load is still on the bus.
    task automatic load_with_waiting_cmd();
        logic [63:0] addr;
        logic [63:0] a;
        logic [63:0] a2;
        logic [63:0] b2;
        int          lat;
        addr = rand64() & ~64'd7;
        a    = rand64();
        a2   = rand64();
        b2   = rand64();
        send_cmd(rvseed_pkg::alu_add, rvseed_pkg::kind_load_d, a, addr - a, 64'd0);
        drive_cmd(rvseed_pkg::alu_xor, rvseed_pkg::kind_alu, a2, b2, 64'd0);
        wait_result(lat);
        check_result("backpressure load", shadow_read(rvseed_pkg::kind_load_d, addr), lat,
                     mem_min_latency, timeout_cycles);
        @(posedge clk);
        if (!hung) begin
            accepted++;
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        wait_result(lat);
        check_result("backpressure alu", a2 ^ b2, lat, 1, 1);
    endtask

    initial begin
        logic [63:0] dividend;
        cmd_valid      = 1'b0;
        cmd_op         = rvseed_pkg::alu_add;
        cmd_kind       = rvseed_pkg::kind_alu;
        src1           = '0;
        src2           = '0;
        store_data     = '0;
        rst            = 1'b1;
        hung           = 1'b0;
        value_errors   = 0;
        timeout_errors = 0;
        accepted       = 0;
        results        = 0;
        for (int i = 0; i < 512; i++) begin
            shadow[i] = 8'd0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        if (cmd_ready !== 1'b1 || res_valid !== 1'b0) begin
            $display("FAILED reset: expected ready 1 valid 0, actual ready %b valid %b",
                     cmd_ready, res_valid);
            value_errors++;
        end

        for (int i = 0; i < 200 && !hung; i++) begin
            alu_cmd("alu", rvseed_pkg::kind_alu);
        end
        // remu by zero hands back the dividend.
        dividend = rand64();
        run_cmd("remu zero divisor", rvseed_pkg::alu_remu, rvseed_pkg::kind_alu, dividend,
                64'd0, 64'd0, dividend, 1, 1);
        for (int i = 0; i < 30 && !hung; i++) begin
            alu_cmd("alu_w", rvseed_pkg::kind_alu_w);
            alu_cmd("pass_b", rvseed_pkg::kind_pass_b);
        end
        for (int i = 0; i < 60 && !hung; i++) begin
            mem_cmd("store_d", rvseed_pkg::kind_store_d);
            mem_cmd("store_w", rvseed_pkg::kind_store_w);
            mem_cmd("store_b", rvseed_pkg::kind_store_b);
        end
        for (int i = 0; i < 60 && !hung; i++) begin
            mem_cmd("load_d", rvseed_pkg::kind_load_d);
            mem_cmd("load_w", rvseed_pkg::kind_load_w);
            mem_cmd("load_bu", rvseed_pkg::kind_load_bu);
        end
        for (int i = 0; i < 10 && !hung; i++) begin
            load_with_waiting_cmd();
        end

        repeat (4) @(negedge clk);
        if (!hung && results != accepted) begin
            $display("FAILED result count: expected %0d, actual %0d", accepted, results);
            value_errors++;
        end
        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- all.f
rvseed_pkg.sv
apb_if.sv
rvseed_alu.sv
rvseed_lsu.sv
rvseed_dmem.sv
rvseed_exec.sv
tb_rvseed_exec.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_rvseed_exec -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation ended with an error status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
